/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - design
    files:
      - design/fetch_pkg.sv
      - design/fetch_cfg_regs.sv
      - design/fetch_unit.sv
      - design/uncached_ifetch.sv
      - design/instr_mem_ctrl.sv
      - design/fetch_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - bench/tb_fetch.sv

/* bench/tb_fetch.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module tb_fetch import fetch_pkg::*; ();

    localparam int MAX_LAT   = 5;
    localparam int RUN_PAIRS = 3 * 16 + 8;
    // Worst-case pairs at the highest latency plus loading, reset and drains
    localparam int WATCHDOG_CYCLES =
        2 * (RUN_PAIRS * (2 * MAX_LAT + 4) + 2 * (`FETCH_MEM_WORDS + 16) + 8 + 48);

    logic       clk;
    logic       rst_n;
    cfg_write_t cfg_i;
    logic       flush_i;
    fetch_rsp_t rsp_1_o;
    fetch_rsp_t rsp_2_o;

    // Reference view of memory and configuration
    logic [`FETCH_DATA_W-1:0] shadow [`FETCH_MEM_WORDS];
    logic [`FETCH_ADDR_W-1:0] boot_model;
    int                       lat_model;
    logic [`FETCH_ADDR_W-1:0] rewrite_addr;
    logic [`FETCH_DATA_W-1:0] rewrite_data;
    logic                     rewrite_armed;

    // Response bookkeeping
    int                       cycle;
    int                       rsp1_cycle;
    int                       rsp1_count;
    int                       rsp2_count;
    logic [`FETCH_ADDR_W-1:0] last_rsp1_addr;
    logic [`FETCH_ADDR_W-1:0] next_rsp1_addr;
    logic                     enabled_once;
    logic                     await_boot;
    logic                     enable_wr;

    int          value_errors = 0;
    int          other_errors = 0;
    logic [31:0] seed;

    fetch_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_i   (cfg_i),
        .flush_i (flush_i),
        .rsp_1_o (rsp_1_o),
        .rsp_2_o (rsp_2_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    assign enable_wr = cfg_i.we && (cfg_i.op == CFG_ENABLE) && cfg_i.data[0];

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string msg);
        value_errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    task automatic write_cfg(input cfg_op_e op, input logic [31:0] data);
        @(posedge clk);
        cfg_i <= '{we: 1'b1, op: op, data: data};
        @(posedge clk);
        cfg_i <= '0;
    endtask

    task automatic set_latency(input int value);
        write_cfg(CFG_LATENCY, value);
        lat_model = (value == 0) ? 1 : value;
    endtask

    task automatic run_pairs(input int n);
        int target;
        target = rsp2_count + n;
        while (rsp2_count < target) @(negedge clk);
    endtask

    task automatic wait_rsp1();
        int target;
        target = rsp1_count + 1;
        while (rsp1_count < target) @(negedge clk);
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
    endtask

    // A pair lasts at most 2L+3 cycles once the last one is issued
    task automatic stop_and_drain();
        write_cfg(CFG_ENABLE, 32'h0);
        repeat (2 * lat_model + 6) @(posedge clk);
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle          <= 0;
            rsp1_cycle     <= 0;
            rsp1_count     <= 0;
            rsp2_count     <= 0;
            last_rsp1_addr <= '0;
            next_rsp1_addr <= '0;
            enabled_once   <= 1'b0;
            await_boot     <= 1'b0;
        end else begin
            cycle <= cycle + 1;
            if (enable_wr) begin
                enabled_once <= 1'b1;
            end
            // Enable and flush both restart the stream at the boot PC
            if (flush_i || enable_wr) begin
                next_rsp1_addr <= boot_model;
            end else if (rsp_1_o.valid) begin
                next_rsp1_addr <= next_rsp1_addr + 32'd8;
            end
            if (rsp_1_o.valid) begin
                rsp1_cycle     <= cycle;
                rsp1_count     <= rsp1_count + 1;
                last_rsp1_addr <= next_rsp1_addr;
            end
            if (rsp_2_o.valid) begin
                rsp2_count <= rsp2_count + 1;
            end
            if (flush_i) begin
                await_boot <= 1'b1;
            end else if (rsp_1_o.valid && rsp_1_o.addr == boot_model) begin
                await_boot <= 1'b0;
            end
        end
    end

    idle_before_enable: assert property (@(posedge clk)
        !enabled_once |-> (!rsp_1_o.valid && !rsp_2_o.valid))
        else report_mismatch("response valid before the first enable");

    rsp_1_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !rsp_1_o.valid |-> (rsp_1_o == '0))
        else report_mismatch("rsp_1 fields nonzero while not valid");

    rsp_2_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !rsp_2_o.valid |-> (rsp_2_o == '0))
        else report_mismatch("rsp_2 fields nonzero while not valid");

    rsp_1_data: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_1_o.valid |-> (rsp_1_o.data == shadow[rsp_1_o.addr[7:2]]))
        else report_mismatch("rsp_1 data differs from memory");

    rsp_2_data: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_2_o.valid |-> (rsp_2_o.data == shadow[rsp_2_o.addr[7:2]]))
        else report_mismatch("rsp_2 data differs from memory");

    rsp_1_order: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_1_o.valid |-> (rsp_1_o.addr == next_rsp1_addr))
        else report_mismatch("rsp_1 address out of sequence");

    rsp_2_order: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_2_o.valid |-> (rsp_2_o.addr == last_rsp1_addr + 32'd4))
        else report_mismatch("rsp_2 address is not rsp_1 address plus 4");

    rsp_2_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_2_o.valid |-> (cycle - rsp1_cycle == lat_model + 1))
        else report_mismatch("rsp_2 spacing from rsp_1 is not latency plus 1");

    flush_restart: assert property (@(posedge clk) disable iff (!rst_n)
        (await_boot && (rsp_1_o.valid || rsp_2_o.valid)) |->
            (rsp_1_o.valid && rsp_1_o.addr == boot_model))
        else report_mismatch("response after flush before the boot PC");

    rewrite_value: assert property (@(posedge clk) disable iff (!rst_n)
        (rewrite_armed && rsp_2_o.valid && rsp_2_o.addr == rewrite_addr) |->
            (rsp_2_o.data == rewrite_data))
        else report_mismatch("rewritten word returned with its old value");

    initial begin
        rst_n         = 1'b0;
        cfg_i         = '0;
        flush_i       = 1'b0;
        boot_model    = `FETCH_BOOT_PC_RST;
        lat_model     = `FETCH_LAT_RST;
        rewrite_addr  = '0;
        rewrite_data  = '0;
        rewrite_armed = 1'b0;
        seed          = 32'h128518c3;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Fill the whole memory with LCG words
        write_cfg(CFG_MEM_ADDR, 32'h0);
        for (int i = 0; i < `FETCH_MEM_WORDS; i++) begin
            seed      = next_random(seed);
            shadow[i] = seed;
            write_cfg(CFG_MEM_DATA, seed);
        end

        // Reset latency of 2
        write_cfg(CFG_ENABLE, 32'h1);
        run_pairs(16);
        stop_and_drain();

        // Zero latency clamps to 1
        // Second pair's rsp_2 word gets a new value
        set_latency(0);
        rewrite_addr = boot_model + 32'd12;
        rewrite_data = ~shadow[rewrite_addr[7:2]];
        write_cfg(CFG_MEM_ADDR, rewrite_addr);
        write_cfg(CFG_MEM_DATA, rewrite_data);
        shadow[rewrite_addr[7:2]] = rewrite_data;
        rewrite_armed = 1'b1;
        write_cfg(CFG_ENABLE, 32'h1);
        run_pairs(16);
        stop_and_drain();

        // New boot PC at latency 5
        // Flush lands between rsp_1 and rsp_2
        boot_model = 32'h0000_0040;
        write_cfg(CFG_BOOT_PC, boot_model);
        set_latency(5);
        write_cfg(CFG_ENABLE, 32'h1);
        run_pairs(16);
        wait_rsp1();
        pulse_flush();
        run_pairs(8);
        stop_and_drain();

        if (await_boot) begin
            other_errors++;
            $display("No response from the boot PC arrived after the flush");
        end
        $display("Checks finished: %0d value errors, %0d other errors",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

/* design/fetch_cfg_regs.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_cfg_regs import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cfg_write_t               cfg_i,
    output logic [`FETCH_ADDR_W-1:0] boot_pc_o,
    output logic                     enable_o,
    output logic [`FETCH_LAT_W-1:0]  latency_o,
    output mem_write_t               mem_wr_o
);

    logic [MEM_IDX_W-1:0]    load_ptr;
    logic [`FETCH_LAT_W-1:0] lat_wr;

    // Zero latency is not meaningful, clamp to one cycle
    assign lat_wr = (cfg_i.data[`FETCH_LAT_W-1:0] == '0) ?
                    `FETCH_LAT_W'(1) : cfg_i.data[`FETCH_LAT_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boot_pc_o <= `FETCH_BOOT_PC_RST;
            enable_o  <= 1'b0;
            latency_o <= `FETCH_LAT_W'(`FETCH_LAT_RST);
            load_ptr  <= '0;
        end else if (cfg_i.we) begin
            case (cfg_i.op)
                CFG_BOOT_PC:  boot_pc_o <= cfg_i.data[`FETCH_ADDR_W-1:0];
                CFG_ENABLE:   enable_o  <= cfg_i.data[0];
                CFG_LATENCY:  latency_o <= lat_wr;
                // Pointer is given as a byte address
                CFG_MEM_ADDR: load_ptr  <= cfg_i.data[MEM_IDX_W+1:2];
                CFG_MEM_DATA: load_ptr  <= load_ptr + MEM_IDX_W'(1);
                default: begin
                end
            endcase
        end
    end

    // Memory write pulse at the current load pointer
    assign mem_wr_o.we    = cfg_i.we && (cfg_i.op == CFG_MEM_DATA);
    assign mem_wr_o.index = load_ptr;
    assign mem_wr_o.data  = cfg_i.data[`FETCH_DATA_W-1:0];

    // Boot PC must be a legal fetch address
    boot_pc_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (cfg_i.we && cfg_i.op == CFG_BOOT_PC) |->
            (cfg_i.data != '0 && cfg_i.data[1:0] == 2'b00))
        else $error("boot PC written as zero or unaligned");

endmodule

/* design/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Instruction address width
`define FETCH_ADDR_W 32

// Instruction word width
`define FETCH_DATA_W 32

// Memory depth in words, indexed by address bits 7:2
`define FETCH_MEM_WORDS 64

// Boot PC after reset, nonzero since zero means no request
`define FETCH_BOOT_PC_RST 32'h0000_0010

// Memory latency after reset
`define FETCH_LAT_RST 2

// Width of the latency field
`define FETCH_LAT_W 4

`endif

/* design/fetch_pkg.sv */
`include "fetch_defs.svh"

package fetch_pkg;

    localparam int unsigned MEM_IDX_W = $clog2(`FETCH_MEM_WORDS);

    // Configuration opcodes
    typedef enum logic [2:0] {
        CFG_BOOT_PC,
        CFG_ENABLE,
        CFG_LATENCY,
        CFG_MEM_ADDR,
        CFG_MEM_DATA
    } cfg_op_e;

    typedef struct packed {
        logic        we;
        cfg_op_e     op;
        logic [31:0] data;
    } cfg_write_t;

    // One word write into the instruction memory
    typedef struct packed {
        logic                     we;
        logic [MEM_IDX_W-1:0]     index;
        logic [`FETCH_DATA_W-1:0] data;
    } mem_write_t;

    // Both addresses zero means no request
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] addr_1;
        logic [`FETCH_ADDR_W-1:0] addr_2;
    } fetch_req_t;

    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] addr;
        logic [`FETCH_DATA_W-1:0] data;
    } fetch_rsp_t;

    typedef enum logic [1:0] {
        ACCEPT_ADDR,
        IN_TRANSACTION_1,
        IN_TRANSACTION_2
    } ifetch_state_e;

    typedef enum logic {
        MEM_IDLE,
        MEM_WAIT
    } mem_state_e;

endpackage

/* design/fetch_top.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_top import fetch_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  cfg_write_t cfg_i,
    input  logic       flush_i,
    output fetch_rsp_t rsp_1_o,
    output fetch_rsp_t rsp_2_o
);

    logic [`FETCH_ADDR_W-1:0] boot_pc;
    logic                     enable;
    logic [`FETCH_LAT_W-1:0]  latency;
    mem_write_t               mem_wr;
    fetch_req_t               req;
    logic                     stallreq;
    logic [`FETCH_ADDR_W-1:0] mem_addr;
    logic                     mem_busy;
    logic [`FETCH_DATA_W-1:0] mem_data;

    fetch_cfg_regs cfg_regs0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_i     (cfg_i),
        .boot_pc_o (boot_pc),
        .enable_o  (enable),
        .latency_o (latency),
        .mem_wr_o  (mem_wr)
    );

    fetch_unit fetch_unit0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .boot_pc_i  (boot_pc),
        .enable_i   (enable),
        .flush_i    (flush_i),
        .stallreq_i (stallreq),
        .req_o      (req)
    );

    uncached_ifetch ifetch0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush_i    (flush_i),
        .req_i      (req),
        .stallreq_o (stallreq),
        .rsp_1_o    (rsp_1_o),
        .rsp_2_o    (rsp_2_o),
        .mem_addr_o (mem_addr),
        .mem_data_i (mem_data),
        .mem_busy_i (mem_busy)
    );

    instr_mem_ctrl mem_ctrl0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .latency_i  (latency),
        .mem_wr_i   (mem_wr),
        .mem_addr_i (mem_addr),
        .mem_busy_o (mem_busy),
        .mem_data_o (mem_data)
    );

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`FETCH_ADDR_W-1:0] boot_pc_i,
    input  logic                     enable_i,
    input  logic                     flush_i,
    input  logic                     stallreq_i,
    output fetch_req_t               req_o
);

    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     enable_q;
    logic                     enable_rise;
    logic                     issued_last;
    logic                     issue;

    assign enable_rise = enable_i && !enable_q;

    // A pair still on req_o has not been seen as stall yet
    assign issued_last = (req_o.addr_1 != '0);

    // Rising enable reloads the PC first, so issue only once enable has settled
    assign issue = enable_i && enable_q && !stallreq_i && !issued_last && !flush_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= 1'b0;
        end else begin
            enable_q <= enable_i;
        end
    end

    // PC update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `FETCH_BOOT_PC_RST;
        end else if (flush_i || enable_rise) begin
            pc <= boot_pc_i;
        end else if (issue) begin
            pc <= pc + `FETCH_ADDR_W'(8);
        end
    end

    // Request is a one-cycle pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_o <= '0;
        end else if (issue) begin
            req_o.addr_1 <= pc;
            req_o.addr_2 <= pc + `FETCH_ADDR_W'(4);
        end else begin
            req_o <= '0;
        end
    end

    // Back-to-back pairs would be lost by the fetch block
    req_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (req_o != '0) |=> (req_o == '0))
        else $error("fetch request held for two cycles");

endmodule

/* design/instr_mem_ctrl.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module instr_mem_ctrl import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`FETCH_LAT_W-1:0]  latency_i,
    input  mem_write_t               mem_wr_i,
    input  logic [`FETCH_ADDR_W-1:0] mem_addr_i,
    output logic                     mem_busy_o,
    output logic [`FETCH_DATA_W-1:0] mem_data_o
);

    logic [`FETCH_DATA_W-1:0] mem [`FETCH_MEM_WORDS];

    mem_state_e              state;
    logic [`FETCH_LAT_W-1:0] cnt;
    logic [MEM_IDX_W-1:0]    rd_idx;
    logic                    rd_start;

    assign rd_start = (state == MEM_IDLE) && (mem_addr_i != '0);

    // Loading port
    always_ff @(posedge clk) begin
        if (mem_wr_i.we) begin
            mem[mem_wr_i.index] <= mem_wr_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            rd_idx <= mem_addr_i[MEM_IDX_W+1:2];
        end
    end

    // The address cycle already counts as one busy cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MEM_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (rd_start) begin
                        state <= MEM_WAIT;
                        cnt   <= latency_i - `FETCH_LAT_W'(1);
                    end
                end
                MEM_WAIT: begin
                    if (cnt == '0) begin
                        state <= MEM_IDLE;
                    end else begin
                        cnt <= cnt - `FETCH_LAT_W'(1);
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    // Busy drops in the same cycle the word is presented
    assign mem_busy_o = (state == MEM_IDLE) ? (mem_addr_i != '0) : (cnt != '0);
    assign mem_data_o = (state == MEM_WAIT && cnt == '0) ? mem[rd_idx] : '0;

    no_addr_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_addr_i != '0) |-> (state == MEM_IDLE))
        else $error("new memory address during a pending read");

endmodule

/* design/uncached_ifetch.sv */
`timescale 1ns/1ns
`include "fetch_defs.svh"

module uncached_ifetch import fetch_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush_i,
    input  fetch_req_t               req_i,
    output logic                     stallreq_o,
    output fetch_rsp_t               rsp_1_o,
    output fetch_rsp_t               rsp_2_o,
    output logic [`FETCH_ADDR_W-1:0] mem_addr_o,
    input  logic [`FETCH_DATA_W-1:0] mem_data_i,
    input  logic                     mem_busy_i
);

    ifetch_state_e state;
    ifetch_state_e next_state;

    logic [`FETCH_ADDR_W-1:0] addr_q_1;
    logic [`FETCH_ADDR_W-1:0] addr_q_2;
    logic                     req_valid;
    logic                     drop_q;
    logic                     kill;
    logic                     last_done;

    assign req_valid = (req_i.addr_1 != '0) || (req_i.addr_2 != '0);
    assign last_done = (state == IN_TRANSACTION_2) && !mem_busy_i;

    // Flush in this cycle also hides a response registered now
    assign kill = drop_q || flush_i;

    always_comb begin
        next_state = state;
        case (state)
            ACCEPT_ADDR: begin
                if (req_valid) next_state = IN_TRANSACTION_1;
            end
            IN_TRANSACTION_1: begin
                if (!mem_busy_i) next_state = IN_TRANSACTION_2;
            end
            IN_TRANSACTION_2: begin
                if (!mem_busy_i) next_state = ACCEPT_ADDR;
            end
            default: next_state = ACCEPT_ADDR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ACCEPT_ADDR;
        end else begin
            state <= next_state;
        end
    end

    // Pair holding
    always_ff @(posedge clk) begin
        if (state == ACCEPT_ADDR) begin
            addr_q_1 <= req_i.addr_1;
            addr_q_2 <= req_i.addr_2;
        end
    end

    // Drop flag lives until the pair in flight is finished
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_q <= 1'b0;
        end else if (last_done) begin
            drop_q <= 1'b0;
        end else if (flush_i && (state != ACCEPT_ADDR || req_valid)) begin
            drop_q <= 1'b1;
        end
    end

    assign stallreq_o = (state != ACCEPT_ADDR);

    // Memory address pulses, one per read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_addr_o <= '0;
        end else begin
            mem_addr_o <= '0;
            if (state == ACCEPT_ADDR && req_valid) begin
                mem_addr_o <= req_i.addr_1;
            end else if (state == IN_TRANSACTION_1 && !mem_busy_i) begin
                mem_addr_o <= addr_q_2;
            end
        end
    end

    // Responses, tagged with their addresses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_1_o <= '0;
            rsp_2_o <= '0;
        end else begin
            rsp_1_o <= '0;
            rsp_2_o <= '0;
            if (state == IN_TRANSACTION_1 && !mem_busy_i && !kill) begin
                rsp_1_o.valid <= 1'b1;
                rsp_1_o.addr  <= addr_q_1;
                rsp_1_o.data  <= mem_data_i;
            end
            if (last_done && !kill) begin
                rsp_2_o.valid <= 1'b1;
                rsp_2_o.addr  <= addr_q_2;
                rsp_2_o.data  <= mem_data_i;
            end
        end
    end

    // A read is only started right after entering a transaction state
    mem_addr_timing: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_addr_o != '0) |->
            (($past(state) == ACCEPT_ADDR && state == IN_TRANSACTION_1) ||
             ($past(state) == IN_TRANSACTION_1 && state == IN_TRANSACTION_2)))
        else $error("memory address outside a read start");

endmodule

/* files.f */
+incdir+design
design/fetch_pkg.sv
design/fetch_cfg_regs.sv
design/fetch_unit.sv
design/uncached_ifetch.sv
design/instr_mem_ctrl.sv
design/fetch_top.sv
bench/tb_fetch.sv
